//--- hw/router_params.svh
// Router-wide constants, included by the package and every module that sizes ports or decodes flits
`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

// Port count, in the order N=0, E=1, W=2, S=3, L=4
`define NUM_PORTS 5

// Node address, X in the low half and Y in the high half
`define ADDR_W 4

// Input buffer depth in flits
`define FIFO_DEPTH 4

// Flit id codes
`define HEADER 3'd1
`define PAYLOAD 3'd2
`define TAIL 3'd4

`endif

//--- hw/nocPkg.sv
// Flit and port types shared by the router RTL and its testbench, referenced as nocPkg::name
`include "router_params.svh"

package nocPkg;

  // Flit kind, coded as HEADER, PAYLOAD or TAIL
  typedef logic [2:0] flitIdT;

  // Header view of the flit body
  typedef struct packed {
    logic [`ADDR_W-1:0] dst;
    logic [`ADDR_W-1:0] src;
    // Free-running packet tag from the sender
    logic [7:0] tag;
  } headerT;

  // One 16-bit word, read as a header on a header flit
  // and as raw data on payload and tail flits
  typedef union packed {
    headerT hdr;
    logic [15:0] data;
  } flitBodyU;

  // Complete flit as it moves through FIFOs and the crossbar
  typedef struct packed {
    flitIdT id;
    flitBodyU body;
  } flitT;

  // One bit per port, N at bit 0 up to L at bit 4
  typedef logic [`NUM_PORTS-1:0] portVecT;

endpackage

//--- hw/flitChannelIf.sv
// Head-of-line flit channel from one input port to the crossbar and arbiters, one instance per input
`timescale 1ns/100ps
`include "router_params.svh"

interface flitChannelIf;

  // Flit currently at the FIFO head
  nocPkg::flitT head;
  // Head flit is present and has a legal route
  logic headValid;
  // One-hot output port held for the current packet
  nocPkg::portVecT route;
  // Crossbar takes the head flit on this edge
  logic pop;

  // Input port side
  modport src (
    output head, headValid, route,
    input pop
  );

  // Crossbar and arbiter side
  modport sink (
    input head, headValid, route,
    output pop
  );

endinterface

//--- hw/flitFifo.sv
// Synchronous flit buffer for one router input, head flit always presented on rdFlit
`timescale 1ns/100ps
`include "router_params.svh"

module flitFifo #(
  parameter int depth = `FIFO_DEPTH
) (
  input logic clk,
  input logic rst,
  input logic wrEn,
  input nocPkg::flitT wrFlit,
  input logic rdEn,
  output nocPkg::flitT rdFlit,
  output logic full,
  output logic empty
);

  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntW = $clog2(depth + 1);

  // Flit storage
  nocPkg::flitT mem [depth];

  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic doWr;
  logic doRd;

  // Writes while full are dropped, reads while empty do nothing
  assign doWr = wrEn & ~full;
  assign doRd = rdEn & ~empty;

  assign full = (count == cntW'(depth));
  assign empty = (count == '0);

  // Head of queue straight from storage
  assign rdFlit = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (doWr) begin
      mem[wrPtr] <= wrFlit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      // Pointers wrap at depth, which need not be a power of two
      if (doWr) begin
        wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doRd) begin
        rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      // Occupancy only moves when exactly one side is active
      if (doWr && !doRd) begin
        count <= count + 1'b1;
      end else if (doRd && !doWr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- hw/lbdrRoute.sv
// Minimal LBDR route computation for one input, configured during reset and held per packet
`timescale 1ns/100ps
`include "router_params.svh"

module lbdrRoute (
  input logic clk,
  input logic rst,
  input logic [7:0] rxyRst,
  input logic [3:0] cxRst,
  input logic [`ADDR_W-1:0] curAddrRst,
  input nocPkg::flitT headFlit,
  input logic headPresent,
  input logic pop,
  output nocPkg::portVecT route,
  output logic routeValid
);

  localparam int halfW = `ADDR_W / 2;

  // Configuration captured while rst is high
  logic [7:0] rxy;
  logic [3:0] cx;
  logic [`ADDR_W-1:0] curAddr;

  logic [halfW-1:0] curX;
  logic [halfW-1:0] curY;
  logic [halfW-1:0] dstX;
  logic [halfW-1:0] dstY;
  logic n1, e1, w1, s1;
  logic nPort, ePort, wPort, sPort, lPort;
  nocPkg::portVecT routeRaw;
  nocPkg::portVecT routeNext;

  assign curX = curAddr[halfW-1:0];
  assign curY = curAddr[`ADDR_W-1:halfW];
  assign dstX = headFlit.body.hdr.dst[halfW-1:0];
  assign dstY = headFlit.body.hdr.dst[`ADDR_W-1:halfW];

  // Quadrant terms from coordinate comparison
  assign n1 = dstY < curY;
  assign s1 = curY < dstY;
  assign e1 = curX < dstX;
  assign w1 = dstX < curX;

  // Straight moves, or turns allowed by the routing bits, gated by connectivity
  // Rxy order is Rne Rnw Ren Res Rwn Rws Rse Rsw from bit 0, Cx order is N E W S
  assign nPort = ((n1 & ~e1 & ~w1) | (n1 & e1 & rxy[0]) | (n1 & w1 & rxy[1])) & cx[0];
  assign ePort = ((e1 & ~n1 & ~s1) | (e1 & n1 & rxy[2]) | (e1 & s1 & rxy[3])) & cx[1];
  assign wPort = ((w1 & ~n1 & ~s1) | (w1 & n1 & rxy[4]) | (w1 & s1 & rxy[5])) & cx[2];
  assign sPort = ((s1 & ~e1 & ~w1) | (s1 & e1 & rxy[6]) | (s1 & w1 & rxy[7])) & cx[3];
  // Arrived at this node
  assign lPort = ~n1 & ~e1 & ~w1 & ~s1;

  assign routeRaw = {lPort, sPort, wPort, ePort, nPort};
  // No forks, so keep only the lowest set port when two turns are enabled
  assign routeNext = routeRaw & (~routeRaw + 1'b1);

  always_ff @(posedge clk) begin
    if (rst) begin
      rxy <= rxyRst;
      cx <= cxRst;
      curAddr <= curAddrRst;
      route <= '0;
      routeValid <= 1'b0;
    end else if (pop && headFlit.id == `TAIL) begin
      // Packet done, next header gets a fresh decision
      route <= '0;
      routeValid <= 1'b0;
    end else if (!routeValid && headPresent && headFlit.id == `HEADER) begin
      // A zero route is held too, so the packet can be drained
      route <= routeNext;
      routeValid <= 1'b1;
    end
  end

endmodule

//--- hw/routerInPort.sv
// One router input: buffers flits, routes each packet and drains packets that have no legal port
`timescale 1ns/100ps
`include "router_params.svh"

module routerInPort (
  input logic clk,
  input logic rst,
  input nocPkg::flitT inFlit,
  input logic inValid,
  output logic inFull,
  input logic [7:0] rxyRst,
  input logic [3:0] cxRst,
  input logic [`ADDR_W-1:0] curAddrRst,
  flitChannelIf.src chan
);

  nocPkg::flitT headFlit;
  nocPkg::portVecT route;
  logic empty;
  logic routeHeld;
  logic dropPop;
  logic fifoPop;

  // Pops come from the crossbar or from the local drain
  assign fifoPop = chan.pop | dropPop;

  flitFifo flitFifo_inst (
    .clk(clk),
    .rst(rst),
    .wrEn(inValid),
    .wrFlit(inFlit),
    .rdEn(fifoPop),
    .rdFlit(headFlit),
    .full(inFull),
    .empty(empty)
  );

  lbdrRoute lbdrRoute_inst (
    .clk(clk),
    .rst(rst),
    .rxyRst(rxyRst),
    .cxRst(cxRst),
    .curAddrRst(curAddrRst),
    .headFlit(headFlit),
    .headPresent(~empty),
    .pop(fifoPop),
    .route(route),
    .routeValid(routeHeld)
  );

  assign chan.head = headFlit;
  assign chan.route = route;
  // Offer the head to the crossbar only with a real output port
  assign chan.headValid = routeHeld & ~empty & (|route);
  // Unroutable packet, one flit discarded per cycle up to the tail
  assign dropPop = routeHeld & ~empty & ~(|route);

endmodule

//--- hw/portArbiter.sv
// Round-robin arbiter for one router output, grant locked for a whole packet
`timescale 1ns/100ps
`include "router_params.svh"

module portArbiter (
  input logic clk,
  input logic rst,
  input nocPkg::portVecT req,
  input nocPkg::portVecT tailPop,
  output nocPkg::portVecT grant
);

  localparam int idxW = $clog2(`NUM_PORTS);

  // Index of the most recent winner
  logic [idxW-1:0] lastIdx;
  logic [idxW-1:0] pickIdx;
  nocPkg::portVecT pick;
  logic found;
  logic unlock;

  // Granted input has just sent its tail
  assign unlock = |(grant & tailPop);

  // Search starts one past the last winner and wraps around
  always_comb begin
    int idx;
    pick = '0;
    pickIdx = lastIdx;
    found = 1'b0;
    for (int k = 1; k <= `NUM_PORTS; k++) begin
      idx = (int'(lastIdx) + k) % `NUM_PORTS;
      if (!found && req[idx]) begin
        found = 1'b1;
        pick[idx] = 1'b1;
        pickIdx = idxW'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= '0;
      // Input 0 has first priority after reset
      lastIdx <= idxW'(`NUM_PORTS - 1);
    end else if (unlock) begin
      grant <= '0;
    end else if (grant == '0 && found) begin
      // Only an idle output takes a new packet
      grant <= pick;
      lastIdx <= pickIdx;
    end
  end

endmodule

//--- hw/nocRouter.sv
// Five-port wormhole mesh router top: input ports, per-output arbiters and a registered crossbar
`timescale 1ns/100ps
`include "router_params.svh"

module nocRouter (
  input logic clk,
  input logic rst,
  input nocPkg::flitT [`NUM_PORTS-1:0] inFlit,
  input logic [`NUM_PORTS-1:0] inValid,
  output logic [`NUM_PORTS-1:0] inFull,
  output nocPkg::flitT [`NUM_PORTS-1:0] outFlit,
  output logic [`NUM_PORTS-1:0] outValid,
  input logic [7:0] rxyRst,
  input logic [3:0] cxRst,
  input logic [`ADDR_W-1:0] curAddrRst
);

  // Channel signals flattened for loops over inputs and outputs
  nocPkg::flitT headVec [`NUM_PORTS];
  nocPkg::portVecT routeVec [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] headValidVec;
  logic [`NUM_PORTS-1:0] popVec;
  nocPkg::portVecT tailPopVec;
  // Indexed by output, one bit per input
  nocPkg::portVecT reqVec [`NUM_PORTS];
  nocPkg::portVecT grantVec [`NUM_PORTS];
  nocPkg::flitT [`NUM_PORTS-1:0] xbarFlit;
  logic [`NUM_PORTS-1:0] xbarValid;

  flitChannelIf chan [`NUM_PORTS] ();

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : genPort
    routerInPort routerInPort_inst (
      .clk(clk),
      .rst(rst),
      .inFlit(inFlit[p]),
      .inValid(inValid[p]),
      .inFull(inFull[p]),
      .rxyRst(rxyRst),
      .cxRst(cxRst),
      .curAddrRst(curAddrRst),
      .chan(chan[p])
    );

    assign headVec[p] = chan[p].head;
    assign routeVec[p] = chan[p].route;
    assign headValidVec[p] = chan[p].headValid;
    assign chan[p].pop = popVec[p];
    assign tailPopVec[p] = popVec[p] & (chan[p].head.id == `TAIL);

    // Arbiter for output p
    portArbiter portArbiter_inst (
      .clk(clk),
      .rst(rst),
      .req(reqVec[p]),
      .tailPop(tailPopVec),
      .grant(grantVec[p])
    );
  end

  // Requests, pops and crossbar selection
  always_comb begin
    xbarFlit = '0;
    xbarValid = '0;
    popVec = '0;
    for (int o = 0; o < `NUM_PORTS; o++) begin
      for (int i = 0; i < `NUM_PORTS; i++) begin
        reqVec[o][i] = headValidVec[i] & routeVec[i][o];
        // Input moves a flit when its routed output has granted it
        if (grantVec[o][i] && routeVec[i][o] && headValidVec[i]) begin
          popVec[i] = 1'b1;
          xbarValid[o] = 1'b1;
          xbarFlit[o] = headVec[i];
        end
      end
    end
  end

  // Output registers load on the pop edge
  always_ff @(posedge clk) begin
    outFlit <= xbarFlit;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= '0;
    end else begin
      outValid <= xbarValid;
    end
  end

endmodule

//--- dv/nocRouterTb.sv
// Table-driven testbench for nocRouter, run as the simulation top with a reference routing model
`timescale 1ns/100ps
`include "router_params.svh"

module nocRouterTb;

  // One table row per packet, expPort of -1 means the packet is dropped
  typedef struct packed {
    int port;
    int dst;
    int len;
    int delay;
    int phase;
    int expPort;
    int first;
  } pktT;

  // Expected flit tagged with the output it must leave on
  typedef struct packed {
    logic [2:0] port;
    nocPkg::flitT f;
  } expT;

  localparam logic [3:0] curNode = 4'h5;

  logic clk = 1'b0;
  logic rst;
  nocPkg::flitT [`NUM_PORTS-1:0] inFlit;
  logic [`NUM_PORTS-1:0] inValid;
  logic [`NUM_PORTS-1:0] inFull;
  nocPkg::flitT [`NUM_PORTS-1:0] outFlit;
  logic [`NUM_PORTS-1:0] outValid;
  logic [7:0] rxyRst;
  logic [3:0] cxRst;
  logic [3:0] curAddrRst;

  pktT tbl [128];
  int numPkts = 0;
  nocPkg::flitT allFlits [$];
  expT expQ [$];
  // Packets whose header has already arrived
  expT curQ [$];
  // Output per destination for node 5 with Rxy 3C, worked out by hand
  int dirMap [16];
  integer seed = 32'h4b25;
  int valErrs = 0;
  int otherErrs = 0;
  int cycles = 0;
  int limit = 1000000;
  int missing;

  nocRouter nocRouter_inst (
    .clk(clk),
    .rst(rst),
    .inFlit(inFlit),
    .inValid(inValid),
    .inFull(inFull),
    .outFlit(outFlit),
    .outValid(outValid),
    .rxyRst(rxyRst),
    .cxRst(cxRst),
    .curAddrRst(curAddrRst)
  );

  always #2 clk = ~clk;

  // Hang guard
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout: traffic did not finish within %0d cycles", limit);
      $display("Errors: %0d wrong values, %0d other", valErrs, otherErrs);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic checkFlit(string name, nocPkg::flitT got, nocPkg::flitT exp);
    if (got !== exp) begin
      valErrs++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkPort(string name, nocPkg::portVecT got, nocPkg::portVecT exp);
    if (got !== exp) begin
      valErrs++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // LBDR rule, lowest numbered port wins if two turns are allowed
  function automatic int ruleRoute(logic [3:0] dst, logic [7:0] rxy, logic [3:0] cx,
                                   logic [3:0] cur);
    logic n1, e1, w1, s1;
    logic [4:0] ok;
    int r;
    n1 = dst[3:2] < cur[3:2];
    s1 = cur[3:2] < dst[3:2];
    e1 = cur[1:0] < dst[1:0];
    w1 = dst[1:0] < cur[1:0];
    ok[0] = cx[0] && n1 && ((!e1 && !w1) || (e1 && rxy[0]) || (w1 && rxy[1]));
    ok[1] = cx[1] && e1 && ((!n1 && !s1) || (n1 && rxy[2]) || (s1 && rxy[3]));
    ok[2] = cx[2] && w1 && ((!n1 && !s1) || (n1 && rxy[4]) || (s1 && rxy[5]));
    ok[3] = cx[3] && s1 && ((!e1 && !w1) || (e1 && rxy[6]) || (w1 && rxy[7]));
    ok[4] = !(n1 || s1 || e1 || w1);
    r = -1;
    for (int p = `NUM_PORTS - 1; p >= 0; p--) begin
      if (ok[p]) begin
        r = p;
      end
    end
    return r;
  endfunction

  // Adds one packet row and its flits, East is unreachable in phase 1
  task automatic addPkt(int port, int dst, int len, int delay, int phase);
    nocPkg::flitT f;
    int exp;
    exp = (phase == 1 && dirMap[dst] == 1) ? -1 : dirMap[dst];
    tbl[numPkts] = '{port, dst, len, delay, phase, exp, allFlits.size()};
    f.id = `HEADER;
    f.body.hdr.dst = 4'(dst);
    f.body.hdr.src = 4'(port);
    f.body.hdr.tag = 8'(numPkts);
    allFlits.push_back(f);
    for (int j = 0; j <= len; j++) begin
      f.id = (j == len) ? `TAIL : `PAYLOAD;
      f.body.data = 16'($random(seed));
      allFlits.push_back(f);
    end
    numPkts++;
  endtask

  // Reference model, queues the whole packet for its output in one step
  function automatic void predict(int i);
    expT e;
    int r;
    r = ruleRoute(4'(tbl[i].dst), rxyRst, cxRst, curAddrRst);
    if (r != tbl[i].expPort) begin
      otherErrs++;
      $display("Routing rule and table disagree on packet %0d", i);
    end
    for (int j = 0; r >= 0 && j < tbl[i].len + 2; j++) begin
      e.port = 3'(r);
      e.f = allFlits[tbl[i].first + j];
      expQ.push_back(e);
    end
  endfunction

  // Walks this input's rows of the phase, holding back while the FIFO is full
  task automatic sendPort(int p, int ph);
    for (int i = 0; i < numPkts; i++) begin
      if (tbl[i].port == p && tbl[i].phase == ph) begin
        repeat (tbl[i].delay) begin
          @(negedge clk);
          inValid[p] = 1'b0;
        end
        predict(i);
        for (int j = 0; j < tbl[i].len + 2; j++) begin
          @(negedge clk);
          while (inFull[p]) begin
            inValid[p] = 1'b0;
            @(negedge clk);
          end
          inFlit[p] = allFlits[tbl[i].first + j];
          inValid[p] = 1'b1;
        end
      end
    end
    @(negedge clk);
    inValid[p] = 1'b0;
  endtask

  function automatic int openSlot(int o);
    for (int j = 0; j < curQ.size(); j++) begin
      if (curQ[j].port == o) begin
        return j;
      end
    end
    return -1;
  endfunction

  function automatic int headerSlot(int o, nocPkg::flitT f);
    for (int j = 0; j < expQ.size(); j++) begin
      if (expQ[j].port == o && expQ[j].f == f && f.id == `HEADER) begin
        return j;
      end
    end
    return -1;
  endfunction

  // Output monitor, a header opens its packet and later flits must follow it in order
  always @(negedge clk) begin : monitor
    nocPkg::portVecT unexp;
    expT e;
    int k;
    unexp = '0;
    for (int o = 0; o < `NUM_PORTS && !rst; o++) begin
      if (outValid[o]) begin
        k = openSlot(o);
        if (k < 0) begin
          k = headerSlot(o, outFlit[o]);
          if (k < 0) begin
            unexp[o] = 1'b1;
          end else begin
            do begin
              e = expQ[k];
              expQ.delete(k);
              curQ.push_back(e);
            end while (e.f.id != `TAIL);
            k = openSlot(o);
          end
        end
        if (k >= 0) begin
          checkFlit($sformatf("outFlit[%0d]", o), outFlit[o], curQ[k].f);
          curQ.delete(k);
        end
      end
    end
    checkPort("unexpected outValid", unexp, '0);
  end

  initial begin
    rst = 1'b1;
    inFlit = '0;
    inValid = '0;
    rxyRst = 8'h3C;
    cxRst = 4'hF;
    curAddrRst = curNode;
    dirMap = '{2, 0, 1, 1, 2, 4, 1, 1, 2, 3, 1, 1, 2, 3, 1, 1};
    // Local loopback, then N and S racing for East
    addPkt(4, 5, 3, 2, 0);
    addPkt(0, 6, 4, 0, 0);
    addPkt(3, 7, 4, 0, 0);
    // Every input to every destination
    for (int p = 0; p < `NUM_PORTS; p++) begin
      for (int d = 0; d < 16; d++) begin
        addPkt(p, d, d % 3, 0, 0);
      end
    end
    // East link cut, mix of dropped and delivered packets
    addPkt(0, 2, 2, 0, 1);
    addPkt(1, 9, 2, 0, 1);
    addPkt(2, 7, 3, 1, 1);
    addPkt(3, 0, 2, 0, 1);
    addPkt(4, 11, 1, 0, 1);
    addPkt(4, 1, 2, 0, 1);
    addPkt(0, 5, 1, 3, 1);
    limit = 200 + 12 * allFlits.size();
    for (int ph = 0; ph < 2; ph++) begin
      @(negedge clk);
      rst = 1'b1;
      cxRst = (ph == 0) ? 4'hF : 4'hD;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      // Quiet router after reset
      repeat (10) begin
        @(negedge clk);
        checkPort("inFull", inFull, '0);
        checkPort("outValid", outValid, '0);
      end
      fork
        sendPort(0, ph);
        sendPort(1, ph);
        sendPort(2, ph);
        sendPort(3, ph);
        sendPort(4, ph);
      join
      while (expQ.size() != 0 || curQ.size() != 0) begin
        @(negedge clk);
      end
      // Let dropped flits drain before the next reset
      repeat (20) @(negedge clk);
    end
    missing = expQ.size() + curQ.size();
    if (missing != 0) begin
      otherErrs += missing;
      $display("%0d expected flits never arrived", missing);
    end
    $display("Errors: %0d wrong values, %0d other", valErrs, otherErrs);
    if (valErrs == 0 && otherErrs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- nocRouter.f
+incdir+hw
hw/nocPkg.sv
hw/flitChannelIf.sv
hw/flitFifo.sv
hw/lbdrRoute.sv
hw/routerInPort.sv
hw/portArbiter.sv
hw/nocRouter.sv
dv/nocRouterTb.sv
